// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int xlen_w     = 32;
    localparam int csr_addr_w = 12;

    // machine csr addresses
    localparam logic [csr_addr_w-1:0] addr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_mie      = 12'h304;
    localparam logic [csr_addr_w-1:0] addr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] addr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause   = 12'h342;
    localparam logic [csr_addr_w-1:0] addr_mtval    = 12'h343;
    localparam logic [csr_addr_w-1:0] addr_mip      = 12'h344;

    // mstatus fields
    localparam int         mstatus_mie_bit  = 3;
    localparam int         mstatus_mpie_bit = 7;
    localparam int         mstatus_mpp_lo   = 11;
    localparam int         mstatus_mpp_hi   = 12;
    localparam logic [1:0] mpp_machine      = 2'b11;

    // shared bit positions of mie and mip
    localparam int msi_bit = 3;
    localparam int mti_bit = 7;
    localparam int mei_bit = 11;

    // exception causes
    localparam logic [xlen_w-1:0] cause_illegal = 32'd2;
    localparam logic [xlen_w-1:0] cause_ecall_m = 32'd11;

    // interrupt codes, flagged by bit 31 in mcause
    localparam logic [xlen_w-1:0] irq_code_software = 32'd3;
    localparam logic [xlen_w-1:0] irq_code_timer    = 32'd7;
    localparam logic [xlen_w-1:0] irq_code_external = 32'd11;
    localparam int                mcause_int_bit    = 31;

    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_set,
        op_clear
    } csr_op_e;

    localparam logic [6:0] opcode_system = 7'b1110011;
    localparam logic [6:0] funct7_mret   = 7'b0011000;
    localparam logic [4:0] rs2_mret      = 5'b00010;

    // one system word, seen as zicsr or as privileged encoding
    typedef union packed {
        struct packed {
            logic [11:0] csr;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr_fmt;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } priv_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  csr_pkg::instr_u                 instr,
    input  logic [csr_pkg::xlen_w-1:0]      rs1_data,
    output csr_pkg::csr_op_e                csr_op,
    output logic [csr_pkg::csr_addr_w-1:0]  csr_addr,
    output logic [csr_pkg::xlen_w-1:0]      csr_operand,
    output logic [4:0]                      rd_idx,
    output logic                            is_csr,
    output logic                            is_ecall,
    output logic                            is_mret,
    output logic                            is_illegal_enc
);
    import csr_pkg::*;

    logic       is_system;
    logic [2:0] funct3;
    logic       rs1_zero;
    logic       priv_base;

    assign is_system = (instr.csr_fmt.opcode == opcode_system);
    assign funct3    = instr.csr_fmt.funct3;
    assign rs1_zero  = (instr.csr_fmt.rs1 == 5'd0);

    // ecall and mret share funct3 = 0 with rs1 and rd zero
    assign priv_base = is_system
                    && (instr.priv_fmt.funct3 == 3'b000)
                    && (instr.priv_fmt.rs1 == 5'd0)
                    && (instr.priv_fmt.rd == 5'd0);

    assign is_ecall = priv_base
                   && (instr.priv_fmt.funct7 == 7'd0)
                   && (instr.priv_fmt.rs2 == 5'd0);

    assign is_mret = priv_base
                  && (instr.priv_fmt.funct7 == funct7_mret)
                  && (instr.priv_fmt.rs2 == rs2_mret);

    assign is_csr = is_system && (funct3[1:0] != 2'b00);

    // funct3 = 100 is reserved, funct3 = 000 only holds ecall and mret here
    assign is_illegal_enc = is_system
                         && ((funct3 == 3'b100)
                          || ((funct3 == 3'b000) && !is_ecall && !is_mret));

    assign csr_addr = instr.csr_fmt.csr;
    assign rd_idx   = instr.csr_fmt.rd;

    // immediate forms carry a zero-extended uimm in the rs1 field
    assign csr_operand = funct3[2] ? {{(xlen_w - 5){1'b0}}, instr.csr_fmt.rs1}
                                   : rs1_data;

    always_comb begin
        csr_op = op_none;
        if (is_csr) begin
            case (funct3[1:0])
                2'b01:   csr_op = op_write;
                // set or clear from x0 only reads
                2'b10:   csr_op = rs1_zero ? op_none : op_set;
                2'b11:   csr_op = rs1_zero ? op_none : op_clear;
                default: csr_op = op_none;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            irq_external,
    input  logic                            irq_timer,
    input  logic                            irq_software,
    input  csr_pkg::csr_op_e                csr_op,
    input  logic [csr_pkg::csr_addr_w-1:0]  csr_addr,
    input  logic [csr_pkg::xlen_w-1:0]      csr_operand,
    input  logic                            csr_commit,
    input  logic                            trap_take,
    input  logic [csr_pkg::xlen_w-1:0]      trap_cause,
    input  logic [csr_pkg::xlen_w-1:0]      trap_tval,
    input  logic [csr_pkg::xlen_w-1:0]      trap_pc,
    input  logic                            mret_take,
    output logic [csr_pkg::xlen_w-1:0]      csr_rdata,
    output logic                            addr_known,
    output logic                            mstatus_mie,
    output logic [csr_pkg::xlen_w-1:0]      mtvec,
    output logic [csr_pkg::xlen_w-1:0]      mepc,
    output logic [2:0]                      irq_active
);
    import csr_pkg::*;

    // writable bits of mie
    localparam logic [xlen_w-1:0] irq_mask = (32'd1 << msi_bit)
                                           | (32'd1 << mti_bit)
                                           | (32'd1 << mei_bit);

    // mstatus only stores mie and mpie
    logic              mst_mie_q;
    logic              mst_mpie_q;
    logic [xlen_w-1:0] mstatus_val;
    logic [xlen_w-1:0] mie_q;
    logic [xlen_w-1:0] mip_q;
    logic [xlen_w-1:0] mtvec_q;
    logic [xlen_w-1:0] mscratch_q;
    logic [xlen_w-1:0] mepc_q;
    logic [xlen_w-1:0] mcause_q;
    logic [xlen_w-1:0] mtval_q;
    logic              wr_en;
    logic [xlen_w-1:0] wdata;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[mstatus_mpp_hi:mstatus_mpp_lo] = mpp_machine;
        mstatus_val[mstatus_mpie_bit] = mst_mpie_q;
        mstatus_val[mstatus_mie_bit]  = mst_mie_q;
    end

    always_comb begin
        addr_known = 1'b1;
        case (csr_addr)
            addr_mstatus:  csr_rdata = mstatus_val;
            addr_mie:      csr_rdata = mie_q;
            addr_mtvec:    csr_rdata = mtvec_q;
            addr_mscratch: csr_rdata = mscratch_q;
            addr_mepc:     csr_rdata = mepc_q;
            addr_mcause:   csr_rdata = mcause_q;
            addr_mtval:    csr_rdata = mtval_q;
            addr_mip:      csr_rdata = mip_q;
            default: begin
                csr_rdata  = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    // read-modify-write value, masked per register below
    assign wr_en = csr_commit && (csr_op != op_none);

    always_comb begin
        case (csr_op)
            op_write: wdata = csr_operand;
            op_set:   wdata = csr_rdata | csr_operand;
            op_clear: wdata = csr_rdata & ~csr_operand;
            default:  wdata = csr_rdata;
        endcase
    end

    // trap saves mie into mpie, mret restores it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mst_mie_q  <= 1'b0;
            mst_mpie_q <= 1'b1;
        end else if (trap_take) begin
            mst_mpie_q <= mst_mie_q;
            mst_mie_q  <= 1'b0;
        end else if (mret_take) begin
            mst_mie_q  <= mst_mpie_q;
            mst_mpie_q <= 1'b1;
        end else if (wr_en && (csr_addr == addr_mstatus)) begin
            mst_mie_q  <= wdata[mstatus_mie_bit];
            mst_mpie_q <= wdata[mstatus_mpie_bit];
        end
    end

    // irq lines land in mip one cycle later, writes ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip_q <= '0;
        end else begin
            mip_q <= '0;
            mip_q[mei_bit] <= irq_external;
            mip_q[mti_bit] <= irq_timer;
            mip_q[msi_bit] <= irq_software;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q      <= '0;
            mtvec_q    <= MTVEC_RESET;
            mscratch_q <= '0;
        end else if (wr_en) begin
            if (csr_addr == addr_mie) begin
                mie_q <= wdata & irq_mask;
            end
            if (csr_addr == addr_mtvec) begin
                mtvec_q <= {wdata[xlen_w-1:2], 1'b0, wdata[0]};
            end
            if (csr_addr == addr_mscratch) begin
                mscratch_q <= wdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap_take) begin
            mepc_q   <= {trap_pc[xlen_w-1:2], 2'b00};
            mcause_q <= trap_cause;
            mtval_q  <= trap_tval;
        end else if (wr_en) begin
            if (csr_addr == addr_mepc) begin
                mepc_q <= {wdata[xlen_w-1:2], 2'b00};
            end
            if (csr_addr == addr_mcause) begin
                mcause_q <= wdata;
            end
            if (csr_addr == addr_mtval) begin
                mtval_q <= wdata;
            end
        end
    end

    assign mstatus_mie = mst_mie_q;
    assign mtvec       = mtvec_q;
    assign mepc        = mepc_q;

    // [2] external, [1] timer, [0] software
    assign irq_active = {mip_q[mei_bit] & mie_q[mei_bit],
                         mip_q[mti_bit] & mie_q[mti_bit],
                         mip_q[msi_bit] & mie_q[msi_bit]};

    // a trap in the same cycle would drop the csr write
    a_trap_commit_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_take && csr_commit))
        else $error("trap and csr commit strobes high together");

    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_take && mret_take))
        else $error("trap and mret strobes high together");

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  logic                        instr_valid,
    input  logic [csr_pkg::xlen_w-1:0]  pc,
    input  logic [csr_pkg::xlen_w-1:0]  instr,
    input  logic [4:0]                  rd_idx,
    input  logic                        is_csr,
    input  logic                        is_ecall,
    input  logic                        is_mret,
    input  logic                        is_illegal_enc,
    input  logic                        addr_known,
    input  logic [csr_pkg::xlen_w-1:0]  csr_rdata,
    input  logic                        mstatus_mie,
    input  logic [csr_pkg::xlen_w-1:0]  mtvec,
    input  logic [csr_pkg::xlen_w-1:0]  mepc,
    input  logic [2:0]                  irq_active,
    output logic                        trap_take,
    output logic [csr_pkg::xlen_w-1:0]  trap_cause,
    output logic [csr_pkg::xlen_w-1:0]  trap_tval,
    output logic                        mret_take,
    output logic                        csr_commit,
    output logic                        rd_we,
    output logic [4:0]                  rd_addr,
    output logic [csr_pkg::xlen_w-1:0]  rd_data,
    output logic                        redirect_valid,
    output logic [csr_pkg::xlen_w-1:0]  redirect_pc
);
    import csr_pkg::*;

    logic              irq_take;
    logic              illegal;
    logic              exc_take;
    logic [xlen_w-1:0] irq_code;
    logic [xlen_w-1:0] trap_base;

    // an interrupt preempts whatever instruction is presented
    assign irq_take = instr_valid && mstatus_mie && (irq_active != 3'b000);
    assign illegal  = is_illegal_enc || (is_csr && !addr_known);
    assign exc_take = instr_valid && !irq_take && (illegal || is_ecall);

    // external, then software, then timer
    always_comb begin
        if (irq_active[2]) begin
            irq_code = irq_code_external;
        end else if (irq_active[0]) begin
            irq_code = irq_code_software;
        end else begin
            irq_code = irq_code_timer;
        end
    end

    assign trap_take  = irq_take || exc_take;
    assign trap_cause = irq_take ? (irq_code | (32'd1 << mcause_int_bit))
                                 : (illegal ? cause_illegal : cause_ecall_m);
    assign trap_tval  = (!irq_take && illegal) ? instr : '0;

    assign mret_take  = instr_valid && !irq_take && is_mret;
    assign csr_commit = instr_valid && !irq_take && is_csr && addr_known;

    // write-back returns the value before the update
    assign rd_we   = csr_commit && (rd_idx != 5'd0);
    assign rd_addr = rd_idx;
    assign rd_data = csr_rdata;

    assign trap_base      = {mtvec[xlen_w-1:2], 2'b00};
    assign redirect_valid = trap_take || mret_take;

    always_comb begin
        if (mret_take) begin
            redirect_pc = mepc;
        end else if (irq_take && mtvec[0]) begin
            // vectored mode, one word per cause
            redirect_pc = trap_base + (irq_code << 2);
        end else begin
            redirect_pc = trap_base;
        end
    end

    always_comb begin
        a_one_action: assert final ($onehot0({trap_take, mret_take, csr_commit}))
            else $error("more than one of trap, mret and commit at pc %h", pc);
    end

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [csr_pkg::xlen_w-1:0]  instr,
    input  logic [csr_pkg::xlen_w-1:0]  pc,
    input  logic [csr_pkg::xlen_w-1:0]  rs1_data,
    input  logic                        irq_external,
    input  logic                        irq_timer,
    input  logic                        irq_software,
    output logic                        rd_we,
    output logic [4:0]                  rd_addr,
    output logic [csr_pkg::xlen_w-1:0]  rd_data,
    output logic                        redirect_valid,
    output logic [csr_pkg::xlen_w-1:0]  redirect_pc
);
    import csr_pkg::*;

    // decode outputs
    csr_op_e                csr_op;
    logic [csr_addr_w-1:0]  csr_addr;
    logic [xlen_w-1:0]      csr_operand;
    logic [4:0]             rd_idx;
    logic                   is_csr;
    logic                   is_ecall;
    logic                   is_mret;
    logic                   is_illegal_enc;

    // csr file state seen by trap control
    logic [xlen_w-1:0]      csr_rdata;
    logic                   addr_known;
    logic                   mstatus_mie;
    logic [xlen_w-1:0]      mtvec;
    logic [xlen_w-1:0]      mepc;
    logic [2:0]             irq_active;

    // update strobes back into the file
    logic                   trap_take;
    logic [xlen_w-1:0]      trap_cause;
    logic [xlen_w-1:0]      trap_tval;
    logic                   mret_take;
    logic                   csr_commit;

    csr_decode u_decode (
        .instr          (instr),
        .rs1_data       (rs1_data),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_operand    (csr_operand),
        .rd_idx         (rd_idx),
        .is_csr         (is_csr),
        .is_ecall       (is_ecall),
        .is_mret        (is_mret),
        .is_illegal_enc (is_illegal_enc)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_operand  (csr_operand),
        .csr_commit   (csr_commit),
        .trap_take    (trap_take),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .trap_pc      (pc),
        .mret_take    (mret_take),
        .csr_rdata    (csr_rdata),
        .addr_known   (addr_known),
        .mstatus_mie  (mstatus_mie),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .irq_active   (irq_active)
    );

    trap_ctrl u_trap (
        .instr_valid    (instr_valid),
        .pc             (pc),
        .instr          (instr),
        .rd_idx         (rd_idx),
        .is_csr         (is_csr),
        .is_ecall       (is_ecall),
        .is_mret        (is_mret),
        .is_illegal_enc (is_illegal_enc),
        .addr_known     (addr_known),
        .csr_rdata      (csr_rdata),
        .mstatus_mie    (mstatus_mie),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .irq_active     (irq_active),
        .trap_take      (trap_take),
        .trap_cause     (trap_cause),
        .trap_tval      (trap_tval),
        .mret_take      (mret_take),
        .csr_commit     (csr_commit),
        .rd_we          (rd_we),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== csr_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_we,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        exp_rd_we,
    input  logic [4:0]  exp_rd_addr,
    input  logic [31:0] exp_rd_data,
    input  logic        exp_redirect_valid,
    input  logic [31:0] exp_redirect_pc,
    output int          error_count,
    output int          check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
        checks++;
        if (exp_v !== got_v) begin
            errors++;
            $display("Mismatch %s exp %h got %h", name, exp_v, got_v);
        end
    endtask

    // outputs are settled half a period after the inputs change
    always @(negedge clk) begin
        if (rst_n) begin
            compare("rd_we", {31'd0, exp_rd_we}, {31'd0, rd_we});
            compare("redirect_valid", {31'd0, exp_redirect_valid}, {31'd0, redirect_valid});
            if (exp_rd_we) begin
                compare("rd_addr", {27'd0, exp_rd_addr}, {27'd0, rd_addr});
                compare("rd_data", exp_rd_data, rd_data);
            end
            // target only matters when a redirect is expected
            if (exp_redirect_valid) begin
                compare("redirect_pc", exp_redirect_pc, redirect_pc);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;
    import csr_pkg::*;

    localparam int n_cycles   = 3000;
    localparam int max_cycles = 4000;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic        irq_external;
    logic        irq_timer;
    logic        irq_software;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // expected outputs for the cycle being presented
    logic        exp_rd_we;
    logic [4:0]  exp_rd_addr;
    logic [31:0] exp_rd_data;
    logic        exp_redirect_valid;
    logic [31:0] exp_redirect_pc;
    int          error_count;
    int          check_count;

    // reference copy of the machine csrs
    logic        st_mie;
    logic        st_mpie;
    logic [31:0] m_mie;
    logic [31:0] m_mip;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;

    // effects that land on the next rising edge
    logic        pend_trap;
    logic        pend_mret;
    logic        pend_write;
    logic [31:0] pend_cause;
    logic [31:0] pend_tval;
    logic [31:0] pend_pc;
    logic [31:0] pend_wdata;
    logic [11:0] pend_addr;

    logic [11:0] known_addr [8];

    csr_unit uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .irq_external   (irq_external),
        .irq_timer      (irq_timer),
        .irq_software   (irq_software),
        .rd_we          (rd_we),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_checker chk (
        .clk                (clk),
        .rst_n              (rst_n),
        .rd_we              (rd_we),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .exp_rd_we          (exp_rd_we),
        .exp_rd_addr        (exp_rd_addr),
        .exp_rd_data        (exp_rd_data),
        .exp_redirect_valid (exp_redirect_valid),
        .exp_redirect_pc    (exp_redirect_pc),
        .error_count        (error_count),
        .check_count        (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] read_model(input logic [11:0] addr);
        case (addr)
            addr_mstatus:  return 32'h0000_1800 | ({31'd0, st_mpie} << 7) | ({31'd0, st_mie} << 3);
            addr_mie:      return m_mie;
            addr_mtvec:    return m_mtvec;
            addr_mscratch: return m_mscratch;
            addr_mepc:     return m_mepc;
            addr_mcause:   return m_mcause;
            addr_mtval:    return m_mtval;
            addr_mip:      return m_mip;
            default:       return 32'd0;
        endcase
    endfunction

    function automatic logic is_known(input logic [11:0] addr);
        for (int i = 0; i < 8; i++) begin
            if (known_addr[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic reset_model();
        st_mie     = 1'b0;
        st_mpie    = 1'b1;
        m_mie      = 32'd0;
        m_mip      = 32'd0;
        m_mtvec    = 32'h0000_0100;
        m_mscratch = 32'd0;
        m_mepc     = 32'd0;
        m_mcause   = 32'd0;
        m_mtval    = 32'd0;
        pend_trap  = 1'b0;
        pend_mret  = 1'b0;
        pend_write = 1'b0;
    endtask

    // state change at the edge that ended the previous cycle
    task automatic apply_update();
        m_mip     = 32'd0;
        m_mip[11] = irq_external;
        m_mip[7]  = irq_timer;
        m_mip[3]  = irq_software;
        if (pend_trap) begin
            m_mepc   = pend_pc & ~32'd3;
            m_mcause = pend_cause;
            m_mtval  = pend_tval;
            st_mpie  = st_mie;
            st_mie   = 1'b0;
        end else if (pend_mret) begin
            st_mie  = st_mpie;
            st_mpie = 1'b1;
        end else if (pend_write) begin
            case (pend_addr)
                addr_mstatus: begin
                    st_mie  = pend_wdata[3];
                    st_mpie = pend_wdata[7];
                end
                addr_mie:      m_mie = pend_wdata & 32'h0000_0888;
                addr_mtvec:    m_mtvec = pend_wdata & ~32'd2;
                addr_mscratch: m_mscratch = pend_wdata;
                addr_mepc:     m_mepc = pend_wdata & ~32'd3;
                addr_mcause:   m_mcause = pend_wdata;
                addr_mtval:    m_mtval = pend_wdata;
                default: ;
            endcase
        end
        pend_trap  = 1'b0;
        pend_mret  = 1'b0;
        pend_write = 1'b0;
    endtask

    task automatic compute_expect();
        logic [2:0]  f3;
        logic [4:0]  rs1_f;
        logic [4:0]  rd_f;
        logic [11:0] addr;
        logic        sys;
        logic        ecall;
        logic        mret;
        logic        csr_ins;
        logic        illegal;
        logic        irq;
        logic [2:0]  act;
        logic [31:0] code;
        logic [31:0] old;
        logic [31:0] operand;
        f3      = instr[14:12];
        rs1_f   = instr[19:15];
        rd_f    = instr[11:7];
        addr    = instr[31:20];
        sys     = (instr[6:0] == 7'b1110011);
        ecall   = (instr == 32'h0000_0073);
        mret    = (instr == 32'h3020_0073);
        csr_ins = sys && (f3[1:0] != 2'b00);
        illegal = (sys && ((f3 == 3'b100) || ((f3 == 3'b000) && !ecall && !mret)))
               || (csr_ins && !is_known(addr));
        // external beats software beats timer
        act     = {m_mip[11] & m_mie[11], m_mip[7] & m_mie[7], m_mip[3] & m_mie[3]};
        irq     = instr_valid && st_mie && (act != 3'b000);
        code    = act[2] ? 32'd11 : (act[0] ? 32'd3 : 32'd7);
        old     = read_model(addr);
        operand = f3[2] ? {27'd0, rs1_f} : rs1_data;
        exp_rd_we          = 1'b0;
        exp_rd_addr        = rd_f;
        exp_rd_data        = old;
        exp_redirect_valid = 1'b0;
        exp_redirect_pc    = 32'd0;
        if (irq) begin
            pend_trap          = 1'b1;
            pend_cause         = code | 32'h8000_0000;
            pend_tval          = 32'd0;
            pend_pc            = pc;
            exp_redirect_valid = 1'b1;
            exp_redirect_pc    = (m_mtvec & ~32'd3) + (m_mtvec[0] ? (code << 2) : 32'd0);
        end else if (instr_valid && (illegal || ecall)) begin
            pend_trap          = 1'b1;
            pend_cause         = illegal ? 32'd2 : 32'd11;
            pend_tval          = illegal ? instr : 32'd0;
            pend_pc            = pc;
            exp_redirect_valid = 1'b1;
            exp_redirect_pc    = m_mtvec & ~32'd3;
        end else if (instr_valid && mret) begin
            pend_mret          = 1'b1;
            exp_redirect_valid = 1'b1;
            exp_redirect_pc    = m_mepc;
        end else if (instr_valid && csr_ins) begin
            exp_rd_we  = (rd_f != 5'd0);
            pend_write = (f3[1:0] == 2'b01) || (rs1_f != 5'd0);
            pend_addr  = addr;
            case (f3[1:0])
                2'b01:   pend_wdata = operand;
                2'b10:   pend_wdata = old | operand;
                default: pend_wdata = old & ~operand;
            endcase
        end
    endtask

    task automatic drive_read(input logic [11:0] addr);
        instr_valid  = 1'b1;
        instr        = {addr, 5'd0, 3'b010, 5'd1, 7'b1110011};
        pc           = $urandom;
        rs1_data     = $urandom;
        irq_external = 1'b0;
        irq_timer    = 1'b0;
        irq_software = 1'b0;
    endtask

    task automatic drive_random();
        int unsigned sel;
        logic [2:0]  f3;
        logic [2:0]  idx;
        logic [11:0] addr;
        logic [4:0]  rs1_f;
        logic [4:0]  rd_f;
        logic [31:0] word;
        sel   = $urandom % 100;
        f3    = 3'd1 + 3'($urandom % 3);
        f3[2] = ($urandom % 2) == 1;
        idx   = 3'($urandom % 8);
        addr  = (($urandom % 10) < 9) ? known_addr[idx] : 12'($urandom);
        rs1_f = (($urandom % 5) == 0) ? 5'd0 : 5'($urandom);
        rd_f  = (($urandom % 5) == 0) ? 5'd0 : 5'($urandom);
        word  = $urandom;
        instr_valid  = ($urandom % 10) < 8;
        pc           = $urandom;
        rs1_data     = $urandom;
        irq_external = ($urandom % 20) == 0;
        irq_timer    = ($urandom % 20) == 0;
        irq_software = ($urandom % 20) == 0;
        if (sel < 60) begin
            instr = {addr, rs1_f, f3, rd_f, 7'b1110011};
        end else if (sel < 68) begin
            instr = 32'h0000_0073;
        end else if (sel < 76) begin
            instr = 32'h3020_0073;
        end else if (sel < 88) begin
            // reserved funct3 or a stray funct3 = 000 word
            word[14:12] = (($urandom % 2) == 0) ? 3'b100 : 3'b000;
            word[6:0]   = 7'b1110011;
            instr       = word;
        end else begin
            word[6:0] = 7'b0110011;
            instr     = word;
        end
    endtask

    initial begin
        void'($urandom(32'h2693_37f2));
        known_addr = '{addr_mstatus, addr_mie, addr_mtvec, addr_mscratch,
                       addr_mepc, addr_mcause, addr_mtval, addr_mip};
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = 32'd0;
        pc           = 32'd0;
        rs1_data     = 32'd0;
        irq_external = 1'b0;
        irq_timer    = 1'b0;
        irq_software = 1'b0;
        reset_model();
        compute_expect();
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        // read back every csr straight out of reset
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #5;
            apply_update();
            drive_read(known_addr[i]);
            compute_expect();
        end
        for (int n = 0; n < n_cycles; n++) begin
            @(posedge clk);
            #5;
            apply_update();
            drive_random();
            compute_expect();
        end
        @(posedge clk);
        $display("errors: %0d  checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("errors: %0d  checks: %0d", error_count, check_count);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
csr_pkg.sv
csr_decode.sv
csr_file.sv
trap_ctrl.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_csr_unit -f list.f
	./obj_dir/Vtb_csr_unit | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
